//--- common/corePkg.sv
package corePkg;

	localparam int xlen     = 32;	// data width
	localparam int regAddrW = 5;	// register address width

	// major opcodes of the kept instruction set
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opI      = 7'b0010011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra
	} aluFn_t;

	typedef enum logic [1:0] {bSelReg, bSelImm, bSelShamt} bSel_t;	// operand B source

	typedef enum logic [1:0] {pcSelSeq, pcSelBranch, pcSelJal, pcSelJalr} pcSel_t;

	// the four instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iType_t;

	typedef struct packed {
		logic        imm12;
		logic [5:0]  imm10_5;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [3:0]  imm4_1;
		logic        imm11;
		logic [6:0]  opcode;
	} bType_t;

	typedef struct packed {
		logic        imm20;
		logic [9:0]  imm10_1;
		logic        imm11;
		logic [7:0]  imm19_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} jType_t;

	typedef union packed {
		rType_t rType;
		iType_t iType;
		bType_t bType;
		jType_t jType;
	} instr_t;

	// pipe 3, decode output
	typedef struct packed {
		logic                valid;
		logic                we;
		logic                fnLink;	// result is pc+4
		logic                bneq;
		logic                btype;
		logic                j;
		logic                jr;
		logic [regAddrW-1:0] rs1;
		logic [regAddrW-1:0] rs2;
		logic [regAddrW-1:0] rd;
		logic [4:0]          shamt;
		bSel_t               bSel;
		aluFn_t              aluFn;
		pcSel_t              pcSel;
		logic [xlen-1:0]     iImm;
		logic [xlen-1:0]     bImm;
		logic [xlen-1:0]     jImm;
		logic [xlen-1:0]     pc;
	} decodeOut_t;

	// pipe 4, issue output
	typedef struct packed {
		logic                valid;
		logic                we;
		logic                fnLink;
		logic                bneq;
		logic                btype;
		logic                j;
		logic                jr;
		logic [regAddrW-1:0] rd;
		aluFn_t              aluFn;
		pcSel_t              pcSel;
		logic [xlen-1:0]     iImm;
		logic [xlen-1:0]     bImm;
		logic [xlen-1:0]     jImm;
		logic [xlen-1:0]     pc;
		logic [xlen-1:0]     opA;
		logic [xlen-1:0]     opB;
	} issueOut_t;

	// pipe 5, execute output
	typedef struct packed {
		logic                valid;
		logic                we;
		logic                fnLink;
		logic [regAddrW-1:0] rd;
		logic [xlen-1:0]     aluResult;
		logic [xlen-1:0]     linkValue;
		logic                redirect;
		logic [xlen-1:0]     target;
	} execOut_t;

	// pipe 6, the commit port and regfile write port
	typedef struct packed {
		logic                valid;
		logic                we;
		logic [regAddrW-1:0] rd;
		logic [xlen-1:0]     data;
	} commit_t;

endpackage

//--- decode/decodeStage.sv
module decodeStage (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   instrValid,
	input  corePkg::instr_t        instr,
	input  logic [corePkg::xlen-1:0] pc,
	output corePkg::decodeOut_t    dec
);
	import corePkg::*;

	decodeOut_t decNext;	// combinational pipe 3 contents

	// funct3 plus the alternate bit (funct7[5]) select the ALU op
	function automatic aluFn_t aluDecode(input logic [2:0] f3, input logic alt,
		input logic isReg);
		aluFn_t fn;
		unique case (f3)
			3'b000: fn = (isReg && alt) ? aluSub : aluAdd;	// no SUBI
			3'b001: fn = aluSll;
			3'b010: fn = aluSlt;
			3'b011: fn = aluSltu;
			3'b100: fn = aluXor;
			3'b101: fn = alt ? aluSra : aluSrl;	// imm[10] for the immediate form
			3'b110: fn = aluOr;
			default: fn = aluAnd;
		endcase
		return fn;
	endfunction

	always_comb
	begin
		decNext = '0;
		decNext.rs1   = instr.rType.rs1;
		decNext.rs2   = instr.rType.rs2;
		decNext.rd    = instr.rType.rd;
		decNext.shamt = instr.iType.imm[4:0];
		decNext.pc    = pc;
		// sign extended immediates
		decNext.iImm = {{(xlen-12){instr.iType.imm[11]}}, instr.iType.imm};
		decNext.bImm = {{(xlen-13){instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
			instr.bType.imm10_5, instr.bType.imm4_1, 1'b0};
		decNext.jImm = {{(xlen-21){instr.jType.imm20}}, instr.jType.imm20,
			instr.jType.imm19_12, instr.jType.imm11, instr.jType.imm10_1, 1'b0};

		unique case (instr.rType.opcode)
			opR:
			begin
				decNext.valid = 1'b1;
				decNext.we    = 1'b1;
				decNext.bSel  = bSelReg;
				decNext.aluFn = aluDecode(instr.rType.funct3, instr.rType.funct7[5], 1'b1);
			end
			opI:
			begin
				decNext.valid = 1'b1;
				decNext.we    = 1'b1;
				// shifts take shamt, the rest the I immediate
				decNext.bSel  = (instr.iType.funct3[1:0] == 2'b01) ? bSelShamt : bSelImm;
				decNext.aluFn = aluDecode(instr.iType.funct3, instr.rType.funct7[5], 1'b0);
			end
			opBranch:
			begin
				decNext.valid = (instr.bType.funct3[2:1] == 2'b00);	// BEQ, BNE only
				decNext.btype = 1'b1;
				decNext.bneq  = instr.bType.funct3[0];
				decNext.rd    = '0;	// branches never write
				decNext.pcSel = pcSelBranch;
			end
			opJal:
			begin
				decNext.valid  = 1'b1;
				decNext.we     = 1'b1;
				decNext.fnLink = 1'b1;	// rd gets pc+4
				decNext.j      = 1'b1;
				decNext.pcSel  = pcSelJal;
			end
			opJalr:
			begin
				decNext.valid  = 1'b1;
				decNext.we     = 1'b1;
				decNext.fnLink = 1'b1;
				decNext.jr     = 1'b1;
				decNext.pcSel  = pcSelJalr;
			end
			default: decNext.valid = 1'b0;	// unknown opcode is a bubble
		endcase

		if (!instrValid)
			decNext.valid = 1'b0;
		if (decNext.rd == '0)
			decNext.we = 1'b0;	// writes to x0 are dropped here

		// a bubble carries no side effects downstream
		if (!decNext.valid)
		begin
			decNext.we     = 1'b0;
			decNext.fnLink = 1'b0;
			decNext.btype  = 1'b0;
			decNext.j      = 1'b0;
			decNext.jr     = 1'b0;
			decNext.pcSel  = pcSelSeq;
		end
	end

	// pipe 3
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			dec <= '0;
		else
			dec <= decNext;
	end

endmodule

//--- issue/issueStage.sv
module issueStage (
	input  logic                clk,
	input  logic                nrst,
	input  corePkg::decodeOut_t dec,
	input  corePkg::commit_t    wb,	// write port from commit
	output corePkg::issueOut_t  iss
);
	import corePkg::*;

	logic [xlen-1:0] srcA, srcB;	// regfile read data
	logic [xlen-1:0] opBSel;		// operand B before pipe 4
	issueOut_t       issNext;

	regFile rf (
		.clk       (clk),
		.nrst      (nrst),
		.we        (wb.we),
		.writeAddr (wb.rd),
		.sourceA   (dec.rs1),
		.sourceB   (dec.rs2),
		.result    (wb.data),
		.opA       (srcA),
		.opB       (srcB)
	);

	// operand B mux sits ahead of the register
	always_comb
	begin
		unique case (dec.bSel)
			bSelImm:   opBSel = dec.iImm;
			bSelShamt: opBSel = xlen'(dec.shamt);	// zero extended
			default:   opBSel = srcB;
		endcase
	end

	always_comb
	begin
		issNext.valid  = dec.valid;
		issNext.we     = dec.we;
		issNext.fnLink = dec.fnLink;
		issNext.bneq   = dec.bneq;
		issNext.btype  = dec.btype;
		issNext.j      = dec.j;
		issNext.jr     = dec.jr;
		issNext.rd     = dec.rd;
		issNext.aluFn  = dec.aluFn;
		issNext.pcSel  = dec.pcSel;
		issNext.iImm   = dec.iImm;	// JALR base offset
		issNext.bImm   = dec.bImm;
		issNext.jImm   = dec.jImm;
		issNext.pc     = dec.pc;
		issNext.opA    = srcA;
		issNext.opB    = opBSel;
	end

	// pipe 4
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			iss <= '0;
		else
			iss <= issNext;
	end

endmodule

//--- issue/regFile.sv
module regFile (
	input  logic                         clk,
	input  logic                         nrst,
	input  logic                         we,
	input  logic [corePkg::regAddrW-1:0] writeAddr,
	input  logic [corePkg::regAddrW-1:0] sourceA,
	input  logic [corePkg::regAddrW-1:0] sourceB,
	input  logic [corePkg::xlen-1:0]     result,	// write data
	output logic [corePkg::xlen-1:0]     opA,
	output logic [corePkg::xlen-1:0]     opB
);
	import corePkg::*;

	logic [xlen-1:0] regs [1:31];	// x0 is not stored

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && writeAddr != '0)
			regs[writeAddr] <= result;
	end

	// x0 reads zero, a same-cycle write is passed straight through
	assign opA = (sourceA == '0) ? '0 :
		(we && sourceA == writeAddr) ? result : regs[sourceA];
	assign opB = (sourceB == '0) ? '0 :
		(we && sourceB == writeAddr) ? result : regs[sourceB];

endmodule

//--- project.f
common/corePkg.sv
decode/decodeStage.sv
issue/regFile.sv
issue/issueStage.sv
verilog/executeStage.sv
verilog/commitStage.sv
verilog/coreTop.sv
verif/core_properties.sv
verif/coreTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module coreTb -f project.f -o coreSim
status=$?
if [ $status -ne 0 ]
then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/coreSim
status=$?
if [ $status -ne 0 ]
then
	echo "simulation ended with status $status"
	exit $status
fi

exit 0

//--- verif/coreTb.sv
module coreTb;
	timeunit 1ns;
	timeprecision 100ps;
	import corePkg::*;

	localparam int slotBudget = 150;	// upper bound on issue slots over all tests
	localparam int clkPeriod  = 20;

	// one expected commit cycle
	typedef struct packed {
		logic [31:0] due;	// checker edge count when it shows
		logic        valid;
		logic        we;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        redirect;
		logic [31:0] target;
	} commitExp_t;

	logic            clk;
	logic            nrst;
	logic            instrValid;
	instr_t          instr;
	logic [xlen-1:0] pc;
	commit_t         commit;
	logic            redirect;
	logic [xlen-1:0] redirectTarget;

	logic [31:0] regModel [32];	// architectural state, program order
	logic [31:0] pcNext;
	int          edgeCount = 0;	// falling edges seen by the checker
	commitExp_t  expQ [$];

	coreTop DUT (
		.clk            (clk),
		.nrst           (nrst),
		.instrValid     (instrValid),
		.instr          (instr),
		.pc             (pc),
		.commit         (commit),
		.redirect       (redirect),
		.redirectTarget (redirectTarget)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// instruction encoders in ISA field order
	function automatic logic [31:0] rOp(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opR};
	endfunction

	function automatic logic [31:0] iOp(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] bOp(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] jOp(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// RV32I integer op by funct3 where alt picks SUB or SRA
	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// expected commit of one slot that also retires it into regModel
	function automatic commitExp_t predict(input logic v, input logic [31:0] w,
		input logic [31:0] pcV);
		commitExp_t  e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [2:0]  f3;
		e    = '0;
		f3   = w[14:12];
		a    = regModel[w[19:15]];
		b    = regModel[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		e.rd = w[11:7];
		if (v)
		begin
			case (w[6:0])
				opR:
				begin
					e.valid = 1'b1;
					e.we    = 1'b1;
					e.data  = refAlu(f3, w[30], a, b);
				end
				opI:
				begin
					e.valid = 1'b1;
					e.we    = 1'b1;	// shifts use shamt and there is no SUBI
					e.data  = refAlu(f3, f3 == 3'b101 && w[30], a,
						(f3[1:0] == 2'b01) ? {27'd0, w[24:20]} : immI);
				end
				opBranch:
				begin
					e.valid    = (f3[2:1] == 2'b00);	// only BEQ and BNE
					e.redirect = e.valid && ((a == b) ^ f3[0]);
					e.target   = pcV + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				end
				opJal:
				begin
					e.valid    = 1'b1;
					e.we       = 1'b1;
					e.data     = pcV + 32'd4;
					e.redirect = 1'b1;
					e.target   = pcV + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				opJalr:
				begin
					e.valid    = 1'b1;
					e.we       = 1'b1;
					e.data     = pcV + 32'd4;
					e.redirect = 1'b1;
					e.target   = (a + immI) & ~32'd1;
				end
				default: e.valid = 1'b0;	// not in the kept set
			endcase
		end
		if (e.rd == 5'd0)
			e.we = 1'b0;
		if (e.we)
			regModel[e.rd] = e.data;
		return e;
	endfunction

	task automatic sendSlot(input logic v, input logic [31:0] w);
		commitExp_t e;
		@(posedge clk);
		instrValid <= v;
		instr      <= w;
		pc         <= pcNext;
		e     = predict(v, w, pcNext);
		e.due = 32'(edgeCount + 5);	// sampled next edge and on the port 3 edges later
		expQ.push_back(e);
		pcNext = pcNext + 32'd4;
	endtask

	// two bubbles behind keep any consumer at bypass distance or more
	task automatic issueSpaced(input logic [31:0] w);
		sendSlot(1'b1, w);
		repeat (2) sendSlot(1'b0, $urandom());
	endtask

	task automatic checkVal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Fail %s expected %h got %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic checkCommit(input commitExp_t e);
		checkVal("commit.valid", 32'(e.valid), 32'(commit.valid));
		checkVal("commit.we", 32'(e.we), 32'(commit.we));
		checkVal("redirect", 32'(e.redirect), 32'(redirect));
		if (e.we)
		begin
			checkVal("commit.rd", 32'(e.rd), 32'(commit.rd));
			checkVal("commit.data", e.data, commit.data);
		end
		if (e.redirect)
			checkVal("redirectTarget", e.target, redirectTarget);
	endtask

	// compare each commit cycle at the falling edge
	initial
	begin
		commitExp_t e;
		forever
		begin
			@(negedge clk);
			edgeCount++;
			while (expQ.size() > 0 && expQ[0].due == 32'(edgeCount))
			begin
				e = expQ.pop_front();
				checkCommit(e);
			end
		end
	end

	task automatic resetState();
		@(negedge clk);
		checkVal("commit.valid", 32'd0, 32'(commit.valid));
		checkVal("commit.we", 32'd0, 32'(commit.we));
		checkVal("redirect", 32'd0, 32'(redirect));
	endtask

	task automatic aluRegOps();
		logic [2:0] fn3 [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
		logic [9:0] altBits = 10'b10_0000_0010;	// SUB and SRA
		// x1..x4 get wide random values
		for (int r = 1; r <= 4; r++)
		begin
			issueSpaced(iOp(12'($urandom()), 5'd0, 3'b000, 5'(r), opI));
			issueSpaced(iOp({7'd0, 5'($urandom_range(20, 0))}, 5'(r), 3'b001, 5'(r), opI));
			issueSpaced(iOp(12'($urandom()), 5'(r), 3'b100, 5'(r), opI));
		end
		for (int k = 0; k < 10; k++)
			issueSpaced(rOp({1'b0, altBits[k], 5'd0}, (k % 2 == 0) ? 5'd2 : 5'd4,
				(k % 2 == 0) ? 5'd1 : 5'd3, fn3[k], 5'(10 + k)));
	endtask

	task automatic immAndShift();
		logic [4:0] sh;
		sh = 5'($urandom_range(31, 1));	// nonzero so the three shifts differ
		issueSpaced(iOp({1'b1, 11'($urandom())}, 5'd0, 3'b000, 5'd5, opI));	// negative x5
		issueSpaced(iOp({1'b1, 11'($urandom())}, 5'd1, 3'b000, 5'd13, opI));
		issueSpaced(iOp(12'($urandom()), 5'd5, 3'b100, 5'd14, opI));
		issueSpaced(iOp(12'($urandom()), 5'd5, 3'b010, 5'd15, opI));
		issueSpaced(iOp({7'd0, sh}, 5'd5, 3'b001, 5'd16, opI));
		issueSpaced(iOp({7'd0, sh}, 5'd5, 3'b101, 5'd17, opI));
		issueSpaced(iOp({7'b0100000, sh}, 5'd5, 3'b101, 5'd18, opI));	// sign fill
	endtask

	task automatic bypassAndZero();
		sendSlot(1'b1, iOp(12'($urandom()), 5'd0, 3'b000, 5'd6, opI));
		sendSlot(1'b1, iOp(12'($urandom()), 5'd0, 3'b000, 5'd7, opI));
		sendSlot(1'b0, $urandom());
		issueSpaced(rOp(7'd0, 5'd6, 5'd6, 3'b000, 5'd8));	// x6 still on the write port
		issueSpaced(iOp(12'($urandom()), 5'd1, 3'b000, 5'd0, opI));	// write to x0
		issueSpaced(rOp(7'd0, 5'd1, 5'd0, 3'b000, 5'd9));
		issueSpaced(rOp(7'd0, 5'd0, 5'd0, 3'b110, 5'd19));
	endtask

	task automatic branchesAndJumps();
		logic [12:0] bOff;
		logic [20:0] jOff;
		bOff = 13'({$urandom(), 1'b0});
		jOff = 21'({$urandom(), 1'b0});
		issueSpaced(bOp(bOff, 5'd1, 5'd1, 3'b000));	// beq equal
		issueSpaced(bOp(bOff, 5'd2, 5'd1, 3'b000));
		issueSpaced(bOp(bOff, 5'd2, 5'd1, 3'b001));
		issueSpaced(bOp(bOff, 5'd1, 5'd1, 3'b001));	// bne equal falls through
		issueSpaced(bOp({1'b1, bOff[11:0]}, 5'd3, 5'd1, 3'b001));	// backward
		issueSpaced(jOp(jOff, 5'd21));
		issueSpaced(iOp(12'($urandom()), 5'd1, 3'b000, 5'd22, opJalr));
		issueSpaced(rOp(7'd0, 5'd22, 5'd21, 3'b000, 5'd23));	// both link values
	endtask

	task automatic bubbles();
		sendSlot(1'b1, iOp(12'($urandom()), 5'd0, 3'b000, 5'd24, opI));
		sendSlot(1'b0, $urandom());
		sendSlot(1'b0, $urandom());
		sendSlot(1'b1, iOp(12'($urandom()), 5'd1, 3'b010, 5'd24, 7'b0000011));	// load
		sendSlot(1'b0, $urandom());
		sendSlot(1'b1, bOp(13'd8, 5'd1, 5'd1, 3'b100));	// BLT
		sendSlot(1'b1, iOp(12'd1, 5'd24, 3'b000, 5'd25, opI));	// x24 must be intact
		repeat (2) sendSlot(1'b0, $urandom());
	endtask

	initial
	begin
		void'($urandom(39));
		nrst       = 1'b1;
		instrValid = 1'b0;
		instr      = '0;
		pc         = '0;
		pcNext     = 32'h0000_1000;
		for (int i = 0; i < 32; i++)
			regModel[i] = '0;
		#1 nrst = 1'b0;
		repeat (8) @(posedge clk);
		nrst <= 1'b1;

		resetState();
		aluRegOps();
		immAndShift();
		bypassAndZero();
		branchesAndJumps();
		bubbles();
		repeat (2) sendSlot(1'b0, $urandom());	// flush
		while (expQ.size() != 0)
			@(negedge clk);
		$display("RESULT: PASS");
		$finish;
	end

	initial
	begin
		#((slotBudget + 20) * clkPeriod);
		$display("Watchdog expired before the commit stream drained");
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

endmodule

//--- verif/core_properties.sv
module coreProperties (
	input logic                     clk,
	input logic                     nrst,
	input corePkg::commit_t         commit,
	input logic                     redirect,
	input logic [corePkg::xlen-1:0] redirectTarget
);
	timeunit 1ns;
	timeprecision 100ps;

	// a bubble has no side effects
	bubbleQuiet: assert property (@(posedge clk) disable iff (!nrst)
		!commit.valid |-> (!commit.we && !redirect))
		else $error("write enable or redirect high on a bubble");

	writeNeedsRd: assert property (@(posedge clk) disable iff (!nrst)
		commit.we |-> commit.rd != '0)
		else $error("write enable high with rd x0");

	// pipe 6 held at zero in reset
	resetQuiet: assert property (@(posedge clk)
		!nrst |-> (commit == '0 && !redirect && redirectTarget == '0))
		else $error("outputs not cleared during reset");

endmodule

bind coreTop coreProperties props (
	.clk            (clk),
	.nrst           (nrst),
	.commit         (commit),
	.redirect       (redirect),
	.redirectTarget (redirectTarget)
);

//--- verilog/commitStage.sv
module commitStage (
	input  logic                     clk,
	input  logic                     nrst,
	input  corePkg::execOut_t        ex,
	output corePkg::commit_t         wb,
	output logic                     redirect,
	output logic [corePkg::xlen-1:0] redirectTarget
);
	import corePkg::*;

	logic [xlen-1:0] wbData;

	assign wbData = ex.fnLink ? ex.linkValue : ex.aluResult;	// link or ALU result

	// pipe 6
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wb             <= '0;
			redirect       <= 1'b0;
			redirectTarget <= '0;
		end
		else
		begin
			wb.valid       <= ex.valid;
			wb.we          <= ex.valid & ex.we;	// never write on a bubble
			wb.rd          <= ex.rd;
			wb.data        <= wbData;
			redirect       <= ex.valid & ex.redirect;
			redirectTarget <= ex.target;
		end
	end

endmodule

//--- verilog/coreTop.sv
module coreTop (
	input  logic                     clk,
	input  logic                     nrst,
	input  logic                     instrValid,
	input  corePkg::instr_t          instr,
	input  logic [corePkg::xlen-1:0] pc,
	output corePkg::commit_t         commit,
	output logic                     redirect,
	output logic [corePkg::xlen-1:0] redirectTarget
);
	import corePkg::*;

	decodeOut_t dec;	// pipe 3
	issueOut_t  iss;	// pipe 4
	execOut_t   ex;		// pipe 5

	decodeStage uDecode (
		.clk        (clk),
		.nrst       (nrst),
		.instrValid (instrValid),
		.instr      (instr),
		.pc         (pc),
		.dec        (dec)
	);

	// commit port doubles as the regfile write port
	issueStage uIssue (
		.clk  (clk),
		.nrst (nrst),
		.dec  (dec),
		.wb   (commit),
		.iss  (iss)
	);

	executeStage uExecute (
		.clk  (clk),
		.nrst (nrst),
		.iss  (iss),
		.ex   (ex)
	);

	commitStage uCommit (
		.clk            (clk),
		.nrst           (nrst),
		.ex             (ex),
		.wb             (commit),
		.redirect       (redirect),
		.redirectTarget (redirectTarget)
	);

endmodule

//--- verilog/executeStage.sv
module executeStage (
	input  logic               clk,
	input  logic               nrst,
	input  corePkg::issueOut_t iss,
	output corePkg::execOut_t  ex
);
	import corePkg::*;

	logic [xlen-1:0] aluOut;
	logic [4:0]      shAmt;	// low bits of operand B
	logic            taken;	// branch condition met
	logic [xlen-1:0] tgt;
	execOut_t        exNext;

	assign shAmt = iss.opB[4:0];

	always_comb
	begin
		unique case (iss.aluFn)
			aluAdd:  aluOut = iss.opA + iss.opB;
			aluSub:  aluOut = iss.opA - iss.opB;
			aluAnd:  aluOut = iss.opA & iss.opB;
			aluOr:   aluOut = iss.opA | iss.opB;
			aluXor:  aluOut = iss.opA ^ iss.opB;
			aluSlt:  aluOut = xlen'($signed(iss.opA) < $signed(iss.opB));
			aluSltu: aluOut = xlen'(iss.opA < iss.opB);
			aluSll:  aluOut = iss.opA << shAmt;
			aluSrl:  aluOut = iss.opA >> shAmt;
			aluSra:  aluOut = $unsigned($signed(iss.opA) >>> shAmt);	// arithmetic
			default: aluOut = '0;
		endcase
	end

	// BEQ on equal, BNE on differ
	assign taken = (iss.opA == iss.opB) ^ iss.bneq;

	always_comb
	begin
		unique case (iss.pcSel)
			pcSelBranch: tgt = iss.pc + iss.bImm;
			pcSelJal:    tgt = iss.pc + iss.jImm;
			pcSelJalr:
			begin
				tgt = iss.opA + iss.iImm;
				tgt[0] = 1'b0;	// jalr clears bit 0
			end
			default:     tgt = iss.pc + xlen'(4);
		endcase
	end

	always_comb
	begin
		exNext.valid     = iss.valid;
		exNext.we        = iss.valid & iss.we;
		exNext.fnLink    = iss.fnLink;
		exNext.rd        = iss.rd;
		exNext.aluResult = aluOut;
		exNext.linkValue = iss.pc + xlen'(4);	// return address for jal/jalr
		exNext.redirect  = iss.valid & ((iss.btype & taken) | iss.j | iss.jr);
		exNext.target    = tgt;
	end

	// pipe 5
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			ex <= '0;
		else
			ex <= exNext;
	end

endmodule
